// ==== rtl/bus_controller.sv ====
module bus_controller (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    // CPU side of the bus
    input  soc_pkg::addr_t     bus_address,
    input  soc_pkg::xlen_t     bus_write_data,
    input  soc_pkg::ls_type_t  bus_ls_type,
    input  logic               bus_read_enable,
    input  logic               bus_write_enable,
    output soc_pkg::xlen_t     bus_read_data,
    output logic               bus_read_done,
    output logic               bus_write_done,
    // shared target request lines
    output soc_pkg::addr_t     dev_offset,
    output soc_pkg::ls_type_t  dev_ls_type,
    output soc_pkg::xlen_t     dev_write_data,
    output logic               dev_write,
    // per-target strobes and answers
    output logic               ram_req,
    input  logic               ram_ack,
    input  soc_pkg::xlen_t     ram_read_data,
    output logic               plic_req,
    input  logic               plic_ack,
    input  soc_pkg::xlen_t     plic_read_data
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } state_t;

    state_t   state;
    // transfer held for the whole access
    addr_t    addr_q;
    ls_type_t ls_q;
    xlen_t    wdata_q;
    logic     write_q;
    target_t  target;
    logic     start;
    logic     dev_ack;
    xlen_t    ack_data;

    // one strobe starts a transfer, only seen while idle
    assign start = (state == IDLE) && (bus_read_enable || bus_write_enable);

    // region decode on the latched address
    always_comb begin
        if (addr_q >= RAM_BASE && addr_q < RAM_BASE + RAM_SIZE) begin
            target = TGT_RAM;
        end else if (addr_q >= PLIC_BASE && addr_q < PLIC_BASE + PLIC_SIZE) begin
            target = TGT_PLIC;
        end else begin
            target = TGT_NONE;
        end
    end

    // offset into the selected region
    always_comb begin
        case (target)
            TGT_RAM:  dev_offset = addr_q - RAM_BASE;
            TGT_PLIC: dev_offset = addr_q - PLIC_BASE;
            default:  dev_offset = '0;
        endcase
    end

    assign dev_ls_type    = ls_q;
    assign dev_write_data = wdata_q;
    assign dev_write      = write_q;

    // only the selected target ever acks
    assign dev_ack  = ram_ack || plic_ack;
    assign ack_data = ram_ack ? ram_read_data : plic_read_data;

    // capture address, type and data with the strobe
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            addr_q  <= bus_address;
            ls_q    <= bus_ls_type;
            wdata_q <= bus_write_data;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= IDLE;
            write_q        <= 1'b0;
            ram_req        <= 1'b0;
            plic_req       <= 1'b0;
            bus_read_data  <= '0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
        end else begin
            // requests are single-cycle
            ram_req  <= 1'b0;
            plic_req <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        // read wins if both strobes come together
                        write_q <= !bus_read_enable;
                        if (bus_read_enable) begin
                            bus_read_done <= 1'b0;
                        end else begin
                            bus_write_done <= 1'b0;
                        end
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    // unmapped address gets no request
                    ram_req  <= (target == TGT_RAM);
                    plic_req <= (target == TGT_PLIC);
                    state    <= WAIT;
                end
                WAIT: begin
                    // unmapped completes here with zero data
                    if (target == TGT_NONE || dev_ack) begin
                        if (write_q) begin
                            bus_write_done <= 1'b1;
                        end else begin
                            bus_read_data <= (target == TGT_NONE) ? '0 : ack_data;
                            bus_read_done <= 1'b1;
                        end
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/plic.sv ====
module plic (
    input  logic                            CLOCK_50,
    input  logic                            KEY0,
    input  soc_pkg::addr_t                  dev_offset,
    input  soc_pkg::xlen_t                  dev_write_data,
    input  logic                            dev_write,
    input  logic                            plic_req,
    // level sources, already synchronous
    input  logic [soc_pkg::NUM_SOURCES:1]   irq_sources,
    output logic                            plic_ack,
    output soc_pkg::xlen_t                  plic_read_data,
    output logic                            ext_irq_m,
    output logic                            ext_irq_s
);
    import soc_pkg::*;

    // register file
    prio_t                  src_prio [1:NUM_SOURCES];
    logic [NUM_SOURCES:1]   pending;
    logic [NUM_SOURCES:1]   enable [NUM_CONTEXTS];
    prio_t                  threshold [NUM_CONTEXTS];

    // edge capture
    logic [NUM_SOURCES:1]   src_q;
    logic [NUM_SOURCES:1]   src_rise;
    logic [NUM_SOURCES:1]   pending_next;

    // arbitration results
    prio_t                  best [NUM_CONTEXTS];
    irq_id_t                claim_id [NUM_CONTEXTS];

    // register decode
    irq_id_t                prio_id;
    logic                   prio_ok;
    logic                   pending_hit;
    logic [NUM_CONTEXTS-1:0] enable_hit;
    logic [NUM_CONTEXTS-1:0] thresh_hit;
    logic [NUM_CONTEXTS-1:0] claim_hit;
    xlen_t                  rd_value;

    assign src_rise = irq_sources & ~src_q;

    // priority words at 4 * id, id 0 not backed
    assign prio_id     = dev_offset[4:2];
    assign prio_ok     = (dev_offset[63:5] == '0) && (prio_id != '0) && (prio_id <= NUM_SOURCES);
    assign pending_hit = (dev_offset == PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            enable_hit[c] = dev_offset == PLIC_ENABLE_OFS + addr_t'(c) * PLIC_CTX_ENABLE_STRIDE;
            thresh_hit[c] = dev_offset == PLIC_THRESHOLD_OFS + addr_t'(c) * PLIC_CTX_STRIDE;
            claim_hit[c]  = dev_offset == PLIC_CLAIM_OFS + addr_t'(c) * PLIC_CTX_STRIDE;
        end
    end

    // highest enabled pending source above threshold
    // strict compare keeps ties on the lowest id
    always_comb begin
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            best[c]     = threshold[c];
            claim_id[c] = '0;
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                if (pending[s] && enable[c][s] && src_prio[s] > best[c]) begin
                    best[c]     = src_prio[s];
                    claim_id[c] = irq_id_t'(s);
                end
            end
        end
    end

    assign ext_irq_m = (claim_id[0] != '0);
    assign ext_irq_s = (claim_id[1] != '0);

    // claim read drops the pending bit, a new edge sets it again
    always_comb begin
        pending_next = pending;
        if (plic_req && !dev_write) begin
            for (int c = 0; c < NUM_CONTEXTS; c++) begin
                if (claim_hit[c] && claim_id[c] != '0) begin
                    pending_next[claim_id[c]] = 1'b0;
                end
            end
        end
        pending_next = pending_next | src_rise;
    end

    // read mux, bit 0 of bitmaps is the unused id 0
    always_comb begin
        rd_value = '0;
        if (prio_ok) begin
            rd_value = xlen_t'(src_prio[prio_id]);
        end
        if (pending_hit) begin
            rd_value = xlen_t'({pending, 1'b0});
        end
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            if (enable_hit[c]) begin
                rd_value = xlen_t'({enable[c], 1'b0});
            end
            if (thresh_hit[c]) begin
                rd_value = xlen_t'(threshold[c]);
            end
            if (claim_hit[c]) begin
                rd_value = xlen_t'(claim_id[c]);
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (plic_req) begin
            plic_read_data <= rd_value;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            plic_ack <= 1'b0;
            src_q    <= '0;
            pending  <= '0;
            for (int s = 1; s <= NUM_SOURCES; s++) begin
                src_prio[s] <= '0;
            end
            for (int c = 0; c < NUM_CONTEXTS; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            plic_ack <= plic_req;
            src_q    <= irq_sources;
            pending  <= pending_next;
            // pending and claim writes fall through unused
            if (plic_req && dev_write) begin
                if (prio_ok) begin
                    src_prio[prio_id] <= dev_write_data[2:0];
                end
                for (int c = 0; c < NUM_CONTEXTS; c++) begin
                    if (enable_hit[c]) begin
                        enable[c] <= dev_write_data[NUM_SOURCES:1];
                    end
                    if (thresh_hit[c]) begin
                        threshold[c] <= dev_write_data[2:0];
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/ram_bank.sv ====
module ram_bank (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  soc_pkg::addr_t     dev_offset,
    input  soc_pkg::ls_type_t  dev_ls_type,
    input  soc_pkg::xlen_t     dev_write_data,
    input  logic               dev_write,
    input  logic               ram_req,
    output logic               ram_ack,
    output soc_pkg::xlen_t     ram_read_data
);
    import soc_pkg::*;

    // little-endian words
    word_t      mem [RAM_WORDS];

    // high when on the second word of a doubleword
    logic       beat;
    logic       active;
    logic       mem_we;
    ram_index_t base_index;
    ram_index_t access_index;
    logic [3:0] lane_strb;
    word_t      lane_data;
    word_t      rd_word;
    word_t      shifted;
    // low word held between doubleword beats
    word_t      lo_word;
    xlen_t      load_data;

    assign base_index   = dev_offset[11:2];
    assign access_index = base_index + ram_index_t'(beat);
    assign active       = ram_req || beat;
    assign mem_we       = active && dev_write;

    assign rd_word = mem[access_index];
    // addressed byte moved down to lane 0
    assign shifted = rd_word >> {dev_offset[1:0], 3'b000};

    // byte lanes for stores
    always_comb begin
        case (dev_ls_type)
            LS_B: begin
                lane_strb = 4'b0001 << dev_offset[1:0];
                lane_data = {4{dev_write_data[7:0]}};
            end
            LS_H: begin
                lane_strb = 4'b0011 << dev_offset[1:0];
                lane_data = {2{dev_write_data[15:0]}};
            end
            LS_W: begin
                lane_strb = 4'b1111;
                lane_data = dev_write_data[31:0];
            end
            LS_D: begin
                // low word first, then the upper half
                lane_strb = 4'b1111;
                lane_data = beat ? dev_write_data[63:32] : dev_write_data[31:0];
            end
            default: begin
                lane_strb = 4'b0000;
                lane_data = '0;
            end
        endcase
    end

    // load extraction and extension
    always_comb begin
        case (dev_ls_type)
            LS_B:    load_data = {{56{shifted[7]}}, shifted[7:0]};
            LS_BU:   load_data = {56'b0, shifted[7:0]};
            LS_H:    load_data = {{48{shifted[15]}}, shifted[15:0]};
            LS_HU:   load_data = {48'b0, shifted[15:0]};
            LS_W:    load_data = {{32{rd_word[31]}}, rd_word};
            LS_WU:   load_data = {32'b0, rd_word};
            // only meaningful on the second beat
            LS_D:    load_data = {rd_word, lo_word};
            default: load_data = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (mem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_strb[i]) begin
                    mem[access_index][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    // read data follows every active cycle, valid with the ack
    always_ff @(posedge CLOCK_50) begin
        if (active) begin
            lo_word       <= rd_word;
            ram_read_data <= load_data;
        end
    end

    // doubleword holds off the ack one cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat    <= 1'b0;
            ram_ack <= 1'b0;
        end else if (ram_req && dev_ls_type == LS_D) begin
            beat    <= 1'b1;
            ram_ack <= 1'b0;
        end else begin
            beat    <= 1'b0;
            ram_ack <= active;
        end
    end

endmodule

// ==== rtl/soc_bus_top.sv ====
module soc_bus_top (
    input  logic                            CLOCK_50,
    input  logic                            KEY0,
    input  soc_pkg::addr_t                  bus_address,
    input  soc_pkg::xlen_t                  bus_write_data,
    input  soc_pkg::ls_type_t               bus_ls_type,
    input  logic                            bus_read_enable,
    input  logic                            bus_write_enable,
    input  logic [soc_pkg::NUM_SOURCES:1]   irq_sources,
    output soc_pkg::xlen_t                  bus_read_data,
    output logic                            bus_read_done,
    output logic                            bus_write_done,
    output logic                            ext_irq_m,
    output logic                            ext_irq_s
);
    import soc_pkg::*;

    // request lines shared by both targets
    addr_t    dev_offset;
    ls_type_t dev_ls_type;
    xlen_t    dev_write_data;
    logic     dev_write;

    // per-target handshake
    logic     ram_req;
    logic     ram_ack;
    xlen_t    ram_read_data;
    logic     plic_req;
    logic     plic_ack;
    xlen_t    plic_read_data;

    bus_controller i_bus_controller (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .dev_offset       (dev_offset),
        .dev_ls_type      (dev_ls_type),
        .dev_write_data   (dev_write_data),
        .dev_write        (dev_write),
        .ram_req          (ram_req),
        .ram_ack          (ram_ack),
        .ram_read_data    (ram_read_data),
        .plic_req         (plic_req),
        .plic_ack         (plic_ack),
        .plic_read_data   (plic_read_data)
    );

    // on-chip RAM
    ram_bank i_ram_bank (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .dev_offset     (dev_offset),
        .dev_ls_type    (dev_ls_type),
        .dev_write_data (dev_write_data),
        .dev_write      (dev_write),
        .ram_req        (ram_req),
        .ram_ack        (ram_ack),
        .ram_read_data  (ram_read_data)
    );

    // interrupt controller, no use for the load type
    plic i_plic (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .dev_offset     (dev_offset),
        .dev_write_data (dev_write_data),
        .dev_write      (dev_write),
        .plic_req       (plic_req),
        .irq_sources    (irq_sources),
        .plic_ack       (plic_ack),
        .plic_read_data (plic_read_data),
        .ext_irq_m      (ext_irq_m),
        .ext_irq_s      (ext_irq_s)
    );

endmodule

// ==== rtl/soc_pkg.sv ====
package soc_pkg;

    // bus data and address
    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;

    // on-chip RAM storage
    typedef logic [31:0] word_t;
    typedef logic [9:0]  ram_index_t;

    // interrupt controller fields
    typedef logic [2:0] prio_t;
    // id 0 means no source
    typedef logic [2:0] irq_id_t;

    // load/store type as driven by the CPU
    // stores only use the first four codes
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_t;

    // decoded bus target
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_PLIC
    } target_t;

    // RAM region
    localparam addr_t RAM_BASE  = 64'h0000_0000_8000_0000;
    localparam int    RAM_WORDS = 1024;
    // region size in bytes
    localparam addr_t RAM_SIZE  = addr_t'(RAM_WORDS * 4);

    // interrupt controller region
    localparam addr_t PLIC_BASE = 64'h0000_0000_0C00_0000;
    localparam addr_t PLIC_SIZE = 64'h40_0000;

    // offsets inside the interrupt controller
    // priorities sit at offset 4 * id below the pending word
    localparam addr_t PLIC_PENDING_OFS       = 64'h1000;
    localparam addr_t PLIC_ENABLE_OFS        = 64'h2000;
    localparam addr_t PLIC_CTX_ENABLE_STRIDE = 64'h80;
    localparam addr_t PLIC_THRESHOLD_OFS     = 64'h20_0000;
    localparam addr_t PLIC_CLAIM_OFS         = 64'h20_0004;
    localparam addr_t PLIC_CTX_STRIDE        = 64'h1000;

    // sources are ids 1 to 5
    localparam int NUM_SOURCES  = 5;
    // context 0 machine, context 1 supervisor
    localparam int NUM_CONTEXTS = 2;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the bus testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_soc_bus -Mdir obj_dir \
    && ./obj_dir/Vtb_soc_bus 2>&1 | tee sim.log

grep -q "=== PASS ===" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== test/tb_soc_bus.sv ====
module tb_soc_bus;
    timeunit 1ns;
    timeprecision 100ps;
    import soc_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_XFERS      = 150;
    localparam int XFER_CYCLES    = 6;
    // three times the longest expected run
    localparam int MAX_CYCLES     = (RESET_CYCLES + NUM_XFERS * XFER_CYCLES) * 3;
    localparam int NUM_TEST_WORDS = 6;

    logic             CLOCK_50;
    logic             KEY0;
    addr_t            bus_address;
    xlen_t            bus_write_data;
    ls_type_t         bus_ls_type;
    logic             bus_read_enable;
    logic             bus_write_enable;
    logic [5:1]       irq_sources;
    xlen_t            bus_read_data;
    logic             bus_read_done;
    logic             bus_write_done;
    logic             ext_irq_m;
    logic             ext_irq_s;

    // reference model of RAM and interrupt controller
    word_t            model_mem [RAM_WORDS];
    prio_t            model_prio [1:5];
    logic [5:1]       model_pending;
    logic [5:1]       model_enable [2];
    prio_t            model_thresh [2];

    integer           seed;
    int               cycles = 0;
    // expected strobe-to-done cycles of the transfer in flight
    int               exp_lat;
    logic             dir_read;
    logic             sel_done;

    assign sel_done = dir_read ? bus_read_done : bus_write_done;

    soc_bus_top i_dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .irq_sources      (irq_sources),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ext_irq_m        (ext_irq_m),
        .ext_irq_s        (ext_irq_s)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    task automatic report_failure(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure("timeout, the tests did not finish within the cycle limit");
        end
    end

    // strobe sampled at E, done low for n samples, high on the next
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) && exp_lat == 2
        |-> ##1 !sel_done ##1 !sel_done ##1 sel_done)
        else report_failure("done did not rise 2 cycles after an unmapped strobe");
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) && exp_lat == 3
        |-> ##1 !sel_done ##1 !sel_done ##1 !sel_done ##1 sel_done)
        else report_failure("done did not rise 3 cycles after a single-beat strobe");
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) && exp_lat == 4
        |-> ##1 !sel_done ##1 !sel_done ##1 !sel_done ##1 !sel_done ##1 sel_done)
        else report_failure("done did not rise 4 cycles after a doubleword strobe");

    task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
        assert (got === exp)
        else report_failure($sformatf("%s gave 0x%016h, expected 0x%016h", what, got, exp));
    endtask

    function automatic int expected_latency(input addr_t a, input ls_type_t ls);
        if (a >= RAM_BASE && a < RAM_BASE + 4 * RAM_WORDS) begin
            return (ls == LS_D) ? 4 : 3;
        end else if (a >= PLIC_BASE && a < PLIC_BASE + PLIC_SIZE) begin
            return 3;
        end
        return 2;
    endfunction

    function automatic addr_t ram_addr(input int idx, input logic [1:0] ofs);
        return RAM_BASE + addr_t'(idx) * 4 + addr_t'(ofs);
    endfunction

    // one strobe, then hold address and data until done is back
    task automatic bus_access(input logic is_read, input addr_t addr, input xlen_t data,
                              input ls_type_t ls);
        @(posedge CLOCK_50);
        #5;
        bus_address      = addr;
        bus_write_data   = data;
        bus_ls_type      = ls;
        exp_lat          = expected_latency(addr, ls);
        dir_read         = is_read;
        bus_read_enable  = is_read;
        bus_write_enable = !is_read;
        @(posedge CLOCK_50);
        #5;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        while (!sel_done) begin
            @(posedge CLOCK_50);
            #5;
        end
    endtask

    task automatic bus_write(input addr_t addr, input xlen_t data, input ls_type_t ls);
        bus_access(1'b0, addr, data, ls);
    endtask

    task automatic bus_read(input addr_t addr, input ls_type_t ls, output xlen_t data);
        bus_access(1'b1, addr, '0, ls);
        data = bus_read_data;
    endtask

    // little-endian lane update of the model
    task automatic model_store(input int idx, input logic [1:0] ofs, input xlen_t d,
                               input ls_type_t ls);
        case (ls)
            LS_B: model_mem[idx][8*ofs +: 8] = d[7:0];
            LS_H: model_mem[idx][8*ofs +: 16] = d[15:0];
            LS_W: model_mem[idx] = d[31:0];
            default: begin
                model_mem[idx]     = d[31:0];
                model_mem[idx + 1] = d[63:32];
            end
        endcase
    endtask

    function automatic xlen_t expect_load(input word_t w, input logic [1:0] ofs,
                                          input ls_type_t ls);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*ofs +: 8];
        h = w[8*ofs +: 16];
        case (ls)
            LS_B:    return xlen_t'($signed(b));
            LS_BU:   return xlen_t'(b);
            LS_H:    return xlen_t'($signed(h));
            LS_HU:   return xlen_t'(h);
            LS_W:    return xlen_t'($signed(w));
            default: return xlen_t'(w);
        endcase
    endfunction

    task automatic check_load(input int idx, input logic [1:0] ofs, input ls_type_t ls);
        xlen_t got;
        bus_read(ram_addr(idx, ofs), ls, got);
        check_value($sformatf("%s load of word %0d byte %0d", ls.name(), idx, ofs), got,
                    expect_load(model_mem[idx], ofs, ls));
    endtask

    // top eligible priority first, then the lowest id holding it
    function automatic irq_id_t model_claim(input int ctx);
        prio_t top;
        top = model_thresh[ctx];
        for (int s = 1; s <= 5; s++) begin
            if (model_pending[s] && model_enable[ctx][s] && model_prio[s] > top) begin
                top = model_prio[s];
            end
        end
        if (top == model_thresh[ctx]) begin
            return '0;
        end
        for (int s = 1; s <= 5; s++) begin
            if (model_pending[s] && model_enable[ctx][s] && model_prio[s] == top) begin
                return irq_id_t'(s);
            end
        end
        return '0;
    endfunction

    task automatic check_irq_lines();
        assert (ext_irq_m === (model_claim(0) != 0))
        else report_failure($sformatf("ext_irq_m is %b against the claim rule", ext_irq_m));
        assert (ext_irq_s === (model_claim(1) != 0))
        else report_failure($sformatf("ext_irq_s is %b against the claim rule", ext_irq_s));
    endtask

    // new edges only set pending, edge reaches the register one cycle later
    task automatic raise_sources(input logic [5:1] mask);
        @(posedge CLOCK_50);
        #5;
        model_pending = model_pending | (mask & ~irq_sources);
        irq_sources   = irq_sources | mask;
        repeat (2) @(posedge CLOCK_50);
        #5;
        check_irq_lines();
    endtask

    initial begin
        int      idx [NUM_TEST_WORDS];
        int      k;
        xlen_t   d;
        xlen_t   rd;
        irq_id_t id;
        seed             = 98;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = LS_W;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        irq_sources      = '0;
        dir_read         = 1'b1;
        exp_lat          = 0;
        model_pending    = '0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #5;
        KEY0 = 1'b1;

        // reset state
        check_value("read data after reset", bus_read_data, '0);
        check_value("done and irq levels after reset",
                    xlen_t'({bus_read_done, bus_write_done, ext_irq_m, ext_irq_s}), 64'hc);

        // word stores, then a byte and a half into each word
        for (int i = 0; i < NUM_TEST_WORDS; i++) begin
            idx[i] = i * 160 + ($random(seed) & 127);
            d = {$random(seed), $random(seed)};
            bus_write(ram_addr(idx[i], 2'd0), d, LS_W);
            model_store(idx[i], 2'd0, d, LS_W);
            k = $random(seed) & 3;
            d = {$random(seed), $random(seed)};
            bus_write(ram_addr(idx[i], 2'(k)), d, LS_B);
            model_store(idx[i], 2'(k), d, LS_B);
            k = $random(seed) & 2;
            d = {$random(seed), $random(seed)};
            bus_write(ram_addr(idx[i], 2'(k)), d, LS_H);
            model_store(idx[i], 2'(k), d, LS_H);
        end
        // every load type at every legal offset
        for (int i = 0; i < NUM_TEST_WORDS; i++) begin
            for (int o = 0; o < 4; o++) begin
                check_load(idx[i], 2'(o), LS_B);
                check_load(idx[i], 2'(o), LS_BU);
            end
            for (int o = 0; o < 4; o += 2) begin
                check_load(idx[i], 2'(o), LS_H);
                check_load(idx[i], 2'(o), LS_HU);
            end
            check_load(idx[i], 2'd0, LS_W);
            check_load(idx[i], 2'd0, LS_WU);
        end

        // doublewords, even index keeps the upper word inside RAM
        for (int i = 0; i < 3; i++) begin
            k = ($random(seed) & 'h1ff) * 2;
            d = {$random(seed), $random(seed)};
            bus_write(ram_addr(k, 2'd0), d, LS_D);
            model_store(k, 2'd0, d, LS_D);
            bus_read(ram_addr(k, 2'd0), LS_D, rd);
            check_value("doubleword load", rd, {model_mem[k + 1], model_mem[k]});
            bus_read(ram_addr(k + 1, 2'd0), LS_WU, rd);
            check_value("upper word of doubleword", rd, {32'b0, model_mem[k + 1]});
        end

        // interrupt controller setup
        model_prio[1]   = 3'd2;
        model_prio[2]   = 3'd5;
        model_prio[3]   = 3'd1;
        model_prio[4]   = 3'd5;
        model_prio[5]   = 3'd3;
        model_enable[0] = 5'b01111;
        model_enable[1] = 5'b10000;
        model_thresh[0] = 3'd1;
        model_thresh[1] = 3'd0;
        for (int s = 1; s <= 5; s++) begin
            bus_write(PLIC_BASE + addr_t'(4 * s), xlen_t'(model_prio[s]), LS_W);
        end
        for (int c = 0; c < 2; c++) begin
            bus_write(PLIC_BASE + PLIC_ENABLE_OFS + addr_t'(c) * PLIC_CTX_ENABLE_STRIDE,
                      xlen_t'({model_enable[c], 1'b0}), LS_W);
            bus_write(PLIC_BASE + PLIC_THRESHOLD_OFS + addr_t'(c) * PLIC_CTX_STRIDE,
                      xlen_t'(model_thresh[c]), LS_W);
        end
        bus_read(PLIC_BASE + 64'h8, LS_W, rd);
        check_value("priority of source 2", rd, xlen_t'(model_prio[2]));
        bus_read(PLIC_BASE + PLIC_ENABLE_OFS, LS_W, rd);
        check_value("context 0 enable word", rd, xlen_t'({model_enable[0], 1'b0}));

        // source at the threshold stays quiet
        raise_sources(5'b00100);
        bus_read(PLIC_BASE + PLIC_PENDING_OFS, LS_W, rd);
        check_value("pending bitmap", rd, xlen_t'({model_pending, 1'b0}));
        raise_sources(5'b01011);
        // claims walk down by priority until nothing is left
        do begin
            bus_read(PLIC_BASE + PLIC_CLAIM_OFS, LS_W, rd);
            id = model_claim(0);
            check_value("context 0 claim", rd, xlen_t'(id));
            if (id != 0) begin
                model_pending[id] = 1'b0;
            end
            check_irq_lines();
        end while (id != 0);

        // supervisor context only
        raise_sources(5'b10000);
        bus_read(PLIC_BASE + PLIC_CLAIM_OFS + PLIC_CTX_STRIDE, LS_W, rd);
        id = model_claim(1);
        check_value("context 1 claim", rd, xlen_t'(id));
        model_pending[id] = 1'b0;
        check_irq_lines();

        // unmapped space completes with zero data
        bus_write(64'h0000_0000_1000_0000, 64'hdead_beef, LS_W);
        bus_read(64'h0000_0000_4000_0000, LS_W, rd);
        check_value("unmapped read", rd, '0);
        bus_read(RAM_BASE + 4 * RAM_WORDS, LS_D, rd);
        check_value("read past the RAM region", rd, '0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/soc_pkg.sv
rtl/bus_controller.sv
rtl/ram_bank.sv
rtl/plic.sv
rtl/soc_bus_top.sv
test/tb_soc_bus.sv
